// File: Makefile
TOP = tb_proc

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP) -f project.f

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module decode_stage import proc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  if_id_t      if_id,
   input  logic        redirect,
   input  logic        halted,
   input  ex_mem_t     ex_mem,
   input  wb_t         wb,
   output logic [2:0]  rs_sel,
   output logic [2:0]  rt_sel,
   input  logic [15:0] rs_data,
   input  logic [15:0] rt_data,
   output logic        stall,
   output id_ex_t      id_ex
);

   op_e         op;
   logic [2:0]  rs;
   logic [2:0]  rt;
   logic [2:0]  dst;
   logic        dst_we;
   logic        hit_ex;
   logic        hit_mem;
   logic        hit_wb;
   id_ex_t      decoded;

   assign op = op_e'(if_id.instr[15:11]);

   // Source fields sit in the same place for every format
   assign rs     = if_id.instr[10:8];
   assign rt     = if_id.instr[7:5];
   assign rs_sel = rs;
   assign rt_sel = rt;

   // Destination register and write enable
   always_comb begin
      dst    = rt;
      dst_we = 1'b0;
      case (op)
         OP_RTYPE: begin
            dst    = if_id.instr[4:2];
            dst_we = 1'b1;
         end
         OP_ADDI, OP_LD: dst_we = 1'b1;
         default: dst_we = 1'b0;
      endcase
   end

   // Interlock against every later writer without forwarding
   // EX writer comes from our own ID/EX output
   assign hit_ex  = id_ex.valid && id_ex.we && (rs == id_ex.rd || rt == id_ex.rd);
   assign hit_mem = ex_mem.valid && ex_mem.we && (rs == ex_mem.rd || rt == ex_mem.rd);
   // WB write lands at the end of this cycle and is too late for our read
   assign hit_wb  = wb.we && (rs == wb.rd || rt == wb.rd);

   // Bubbles never stall
   assign stall = if_id.valid && (hit_ex || hit_mem || hit_wb);

   assign decoded = '{instr:  if_id.instr,
                      pc_inc: if_id.pc_inc,
                      rs_val: rs_data,
                      rt_val: rt_data,
                      rd:     dst,
                      we:     dst_we && if_id.valid,
                      valid:  if_id.valid};

   // ID/EX takes a bubble on squash or interlock
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex <= ID_EX_BUBBLE;
      end else if (!halted) begin
         if (redirect || stall) begin
            id_ex <= ID_EX_BUBBLE;
         end else begin
            id_ex <= decoded;
         end
      end
   end

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none
`timescale 1ns/1ps

module execute_stage import proc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  id_ex_t      id_ex,
   input  logic        halted,
   output logic        redirect,
   output logic [15:0] redirect_pc,
   output ex_mem_t     ex_mem
);

   op_e         op;
   alu_op_e     alu_op;
   logic [15:0] imm5;
   logic [15:0] br_off;
   logic [15:0] j_off;
   logic [15:0] op_a;
   logic [15:0] op_b;
   logic [15:0] alu_out;
   logic [15:0] target;
   logic        taken;

   assign op = op_e'(id_ex.instr[15:11]);

   // Sign-extended immediates per format
   assign imm5   = {{11{id_ex.instr[4]}}, id_ex.instr[4:0]};
   assign br_off = {{8{id_ex.instr[7]}}, id_ex.instr[7:0]};
   assign j_off  = {{5{id_ex.instr[10]}}, id_ex.instr[10:0]};

   // A is always rs
   assign op_a = id_ex.rs_val;

   // Operand B and ALU function
   // Address calc for LD and ST is rs plus imm
   always_comb begin
      op_b   = id_ex.rt_val;
      alu_op = ALU_ADD;
      case (op)
         OP_ADDI, OP_LD, OP_ST: op_b = imm5;
         OP_RTYPE: alu_op = alu_op_e'(id_ex.instr[1:0]);
         default: alu_op = ALU_ADD;
      endcase
   end

   // SUB is rs minus rt
   always_comb begin
      case (alu_op)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_XOR: alu_out = op_a ^ op_b;
         ALU_AND: alu_out = op_a & op_b;
         default: alu_out = op_a + op_b;
      endcase
   end

   // Branch decision and a target relative to pc_inc
   always_comb begin
      taken  = 1'b0;
      target = id_ex.pc_inc + br_off;
      case (op)
         OP_BEQZ: taken = (id_ex.rs_val == 16'h0000);
         OP_J: begin
            taken  = 1'b1;
            target = id_ex.pc_inc + j_off;
         end
         default: taken = 1'b0;
      endcase
   end

   // Bubbles never redirect
   assign redirect    = id_ex.valid && taken;
   assign redirect_pc = target;

   // EX/MEM with the rt value as store data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem <= EX_MEM_BUBBLE;
      end else if (!halted) begin
         ex_mem <= '{instr:   id_ex.instr,
                     alu_out: alu_out,
                     st_data: id_ex.rt_val,
                     rd:      id_ex.rd,
                     we:      id_ex.we,
                     valid:   id_ex.valid};
      end
   end

endmodule

`default_nettype wire

// File: fetch_stage.sv
`default_nettype none
`timescale 1ns/1ps

module fetch_stage import proc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        prog_we,
   input  logic [7:0]  prog_addr,
   input  logic [15:0] prog_data,
   input  logic        stall,
   input  logic        redirect,
   input  logic [15:0] redirect_pc,
   input  logic        halted,
   output if_id_t      if_id
);

   logic [15:0] imem [IMEM_DEPTH];
   logic [15:0] pc;
   logic [15:0] pc_inc;
   logic [15:0] fetch_word;

   // Sequential address with 2 bytes per instruction
   assign pc_inc = pc + 16'd2;

   // Word indexed async read
   assign fetch_word = imem[pc[8:1]];

   // Program load only while reset is held
   always_ff @(posedge clk) begin
      if (!rst_n && prog_we) begin
         imem[prog_addr] <= prog_data;
      end
   end

   // PC and IF/ID
   // Halt freeze wins over redirect, which wins over stall hold
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc    <= '0;
         if_id <= IF_ID_BUBBLE;
      end else if (!halted) begin
         if (redirect) begin
            // Younger fetch is on the wrong path
            pc    <= redirect_pc;
            if_id <= IF_ID_BUBBLE;
         end else if (!stall) begin
            pc    <= pc_inc;
            if_id <= '{instr: fetch_word, pc_inc: pc_inc, valid: 1'b1};
         end
      end
   end

endmodule

`default_nettype wire

// File: memory_stage.sv
`default_nettype none
`timescale 1ns/1ps

module memory_stage import proc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  ex_mem_t     ex_mem,
   output wb_t         wb,
   output logic        halted,
   output logic        wb_valid,
   output logic [2:0]  wb_reg,
   output logic [15:0] wb_data
);

   op_e         op;
   logic [15:0] dmem [DMEM_DEPTH];
   logic [15:0] load_data;
   logic        halt_seen;
   logic        freeze;

   assign op = op_e'(ex_mem.instr[15:11]);

   // HALT in MEM/WB already blocks anything younger
   assign freeze = halt_seen;

   // Word indexed by address bits 8 to 1
   assign load_data = dmem[ex_mem.alu_out[8:1]];

   // Data memory stores on a valid ST
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (!freeze && ex_mem.valid && op == OP_ST) begin
         dmem[ex_mem.alu_out[8:1]] <= ex_mem.st_data;
      end
   end

   // MEM/WB plus halt tracking
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb        <= WB_IDLE;
         halt_seen <= 1'b0;
         halted    <= 1'b0;
      end else begin
         // Sticky until reset
         if (halt_seen) begin
            halted <= 1'b1;
         end
         if (!freeze) begin
            wb.rd     <= ex_mem.rd;
            wb.data   <= (op == OP_LD) ? load_data : ex_mem.alu_out;
            wb.we     <= ex_mem.we;
            halt_seen <= ex_mem.valid && op == OP_HALT;
         end
      end
   end

   // Trace straight from MEM/WB
   assign wb_valid = wb.we;
   assign wb_reg   = wb.rd;
   assign wb_data  = wb.data;

endmodule

`default_nettype wire

// File: proc.sv
`default_nettype none
`timescale 1ns/1ps

module proc import proc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        prog_we,
   input  logic [7:0]  prog_addr,
   input  logic [15:0] prog_data,
   output logic        wb_valid,
   output logic [2:0]  wb_reg,
   output logic [15:0] wb_data,
   output logic        halted
);

   // Stage registers
   if_id_t      if_id;
   id_ex_t      id_ex;
   ex_mem_t     ex_mem;
   wb_t         wb;

   // Pipeline control
   logic        stall;
   logic        redirect;
   logic [15:0] redirect_pc;

   // Register file read side
   logic [2:0]  rs_sel;
   logic [2:0]  rt_sel;
   logic [15:0] rs_data;
   logic [15:0] rt_data;

   fetch_stage fetch0 (
      .clk(clk), .rst_n(rst_n),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
      .stall(stall), .redirect(redirect), .redirect_pc(redirect_pc),
      .halted(halted), .if_id(if_id)
   );

   decode_stage decode0 (
      .clk(clk), .rst_n(rst_n), .if_id(if_id),
      .redirect(redirect), .halted(halted), .ex_mem(ex_mem), .wb(wb),
      .rs_sel(rs_sel), .rt_sel(rt_sel), .rs_data(rs_data), .rt_data(rt_data),
      .stall(stall), .id_ex(id_ex)
   );

   // Read in ID and written from WB
   reg_file rf0 (
      .clk(clk), .rst_n(rst_n),
      .rs_sel(rs_sel), .rt_sel(rt_sel), .rs_data(rs_data), .rt_data(rt_data),
      .wb(wb)
   );

   execute_stage execute0 (
      .clk(clk), .rst_n(rst_n), .id_ex(id_ex), .halted(halted),
      .redirect(redirect), .redirect_pc(redirect_pc), .ex_mem(ex_mem)
   );

   memory_stage memory0 (
      .clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .wb(wb), .halted(halted),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
   );

endmodule

`default_nettype wire

// File: proc_golden.hex
// Word 0 program length N, word 1 expected write count M
// Then N program words, then M expected writes as {reg[19:16], data[15:0]}
00017
0000A
04025 // 0  addi r1, r0, 5
0405D // 1  addi r2, r0, -3
0D94C // 2  add  r3, r1, r2
0D951 // 3  sub  r4, r1, r2
0D956 // 4  xor  r5, r1, r2
0D95B // 5  and  r6, r1, r2
0DB9C // 6  add  r7, r3, r4
080E4 // 7  st   r7, 4(r0)
08824 // 8  ld   r1, 4(r0)
06004 // 9  beqz r0, +4 taken
04041 // 10 squashed
04061 // 11 squashed
06104 // 12 beqz r1, +4 not taken
04241 // 13 addi r2, r2, 1
02004 // 14 j +4
0408F // 15 squashed
040AF // 16 squashed
0DF38 // 17 add  r6, r7, r1
00000 // 18 halt
00800 // 19 nop padding
00800
00800
00800
10005
2FFFD
30002
40008
5FFF8
60005
7000A
1000A
2FFFE
60014

// File: proc_pkg.sv
`default_nettype none

package proc_pkg;

   // Memory sizes in 16-bit words
   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;
   localparam int NUM_REGS   = 8;

   // Bubble word that decodes as NOP
   localparam logic [15:0] NOP_INSTR = 16'h0800;

   // Opcode in bits 15 to 11
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_BEQZ  = 5'b01100,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_RTYPE = 5'b11011
   } op_e;

   // R-type function field in bits 1 to 0
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_XOR = 2'b10,
      ALU_AND = 2'b11
   } alu_op_e;

   // IF/ID
   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] pc_inc;
      logic        valid;
   } if_id_t;

   // ID/EX
   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] pc_inc;
      logic [15:0] rs_val;
      logic [15:0] rt_val;
      logic [2:0]  rd;
      logic        we;
      logic        valid;
   } id_ex_t;

   // EX/MEM
   typedef struct packed {
      logic [15:0] instr;
      logic [15:0] alu_out;
      logic [15:0] st_data;
      logic [2:0]  rd;
      logic        we;
      logic        valid;
   } ex_mem_t;

   // MEM/WB that doubles as the register file write port
   typedef struct packed {
      logic [2:0]  rd;
      logic [15:0] data;
      logic        we;
   } wb_t;

   // Empty slots for each stage register
   localparam if_id_t  IF_ID_BUBBLE  = '{instr: NOP_INSTR, pc_inc: '0, valid: 1'b0};
   localparam id_ex_t  ID_EX_BUBBLE  = '{instr: NOP_INSTR, pc_inc: '0, rs_val: '0,
                                         rt_val: '0, rd: '0, we: 1'b0, valid: 1'b0};
   localparam ex_mem_t EX_MEM_BUBBLE = '{instr: NOP_INSTR, alu_out: '0, st_data: '0,
                                         rd: '0, we: 1'b0, valid: 1'b0};
   localparam wb_t     WB_IDLE       = '{rd: '0, data: '0, we: 1'b0};

endpackage

`default_nettype wire

// File: proc_sva.sv
`default_nettype none
`timescale 1ns/1ps

module proc_sva (
   input logic clk,
   input logic rst_n,
   input logic wb_valid,
   input logic halted,
   input logic stall
);

   // Frozen pipeline retires nothing
   a_no_write_halted: assert property (
      @(posedge clk) disable iff (!rst_n) halted |-> !wb_valid)
      else $error("wb_valid high while halted");

   // Sticky until the next reset
   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
      else $error("halted fell without reset");

   // Empty IF/ID cannot interlock
   a_no_stall_at_release: assert property (@(posedge clk) $rose(rst_n) |-> !stall)
      else $error("stall high in the first cycle after reset");

endmodule

// MEM side owns the trace and the halt flag
bind memory_stage proc_sva mem_sva (
   .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .halted(halted), .stall(1'b0)
);

// Decode side owns the interlock and sees MEM/WB
bind decode_stage proc_sva dec_sva (
   .clk(clk), .rst_n(rst_n), .wb_valid(wb.we), .halted(halted), .stall(stall)
);

`default_nettype wire

// File: project.f
proc_pkg.sv
fetch_stage.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
proc.sv
proc_sva.sv
tb_proc.sv

// File: reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file import proc_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic [2:0]  rs_sel,
   input  logic [2:0]  rt_sel,
   output logic [15:0] rs_data,
   output logic [15:0] rt_data,
   input  wb_t         wb
);

   logic [15:0] regs [NUM_REGS];

   // Async reads for decode
   // No write bypass since decode stalls on a pending WB write
   assign rs_data = regs[rs_sel];
   assign rt_data = regs[rt_sel];

   // Single write port from MEM/WB
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.we) begin
         regs[wb.rd] <= wb.data;
      end
   end

endmodule

`default_nettype wire

// File: tb_proc.sv
`default_nettype none
`timescale 1ns/1ps

module tb_proc;

   // Golden image holds length, write count, program and expected writes
   localparam int GOLDEN_WORDS = 64;
   localparam int RESET_CYCLES = 10;

   logic        clk;
   logic        rst_n;
   logic        prog_we;
   logic [7:0]  prog_addr;
   logic [15:0] prog_data;
   logic        wb_valid;
   logic [2:0]  wb_reg;
   logic [15:0] wb_data;
   logic        halted;

   logic [19:0] golden [GOLDEN_WORDS];
   int          n_words;
   int          n_writes;
   int          n_seen;
   int          cycles;
   int          limit;

   proc dut0 (
      .clk(clk), .rst_n(rst_n),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
      .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
      .halted(halted)
   );

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic compare_value(input logic [15:0] actual, input logic [15:0] expected,
                                input string what);
      if (actual !== expected) begin
         $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         $display("Errors found");
         $fatal(1, "Value mismatch");
      end
   endtask

   // Trace and halt flag both low
   task automatic expect_quiet(input string when);
      compare_value({15'b0, wb_valid}, 16'h0000, {"wb_valid ", when});
      compare_value({15'b0, halted}, 16'h0000, {"halted ", when});
   endtask

   // Next expected entry sits after the program words
   task automatic match_write();
      logic [19:0] entry;
      if (n_seen >= n_writes) begin
         $display("Errors found");
         $fatal(1, "Register r%0d was written after the expected list ended", wb_reg);
      end else begin
         entry = golden[2 + n_words + n_seen];
         compare_value({13'b0, wb_reg}, {12'b0, entry[19:16]},
                       $sformatf("wb_reg of write %0d", n_seen));
         compare_value(wb_data, entry[15:0], $sformatf("wb_data of write %0d", n_seen));
         n_seen++;
      end
   endtask

   // One program word per cycle while reset is low
   // Reset stretches past 10 cycles for a longer program
   task automatic load_program();
      int total;
      total = (n_words + 1 > RESET_CYCLES) ? n_words + 1 : RESET_CYCLES;
      for (int i = 0; i < total; i++) begin
         @(posedge clk);
         if (i < n_words) begin
            prog_we   <= 1'b1;
            prog_addr <= 8'(i);
            prog_data <= golden[2 + i][15:0];
         end else begin
            prog_we <= 1'b0;
         end
         @(negedge clk);
         expect_quiet("during reset");
      end
      @(posedge clk);
      rst_n   <= 1'b1;
      prog_we <= 1'b0;
      @(negedge clk);
      expect_quiet("in the first cycle after reset");
   endtask

   initial begin
      rst_n     = 1'b0;
      prog_we   = 1'b0;
      prog_addr = '0;
      prog_data = '0;
      n_seen    = 0;
      cycles    = 0;
      $readmemh("proc_golden.hex", golden);
      n_words  = int'(golden[0]);
      n_writes = int'(golden[1]);
      limit    = 8 * n_words + 50;
      if (n_words < 1 || n_words > 256 || 2 + n_words + n_writes > GOLDEN_WORDS) begin
         $display("Errors found");
         $fatal(1, "The golden file is missing or its header does not fit");
      end else begin
         load_program();
         // Outputs settle after the rising edge
         while (!halted) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
               $display("Errors found");
               $fatal(1, "Timeout: halted did not rise within %0d cycles", limit);
            end else if (wb_valid) begin
               match_write();
            end
         end
         // Frozen pipeline retires nothing more
         repeat (4) begin
            @(negedge clk);
            compare_value({15'b0, wb_valid}, 16'h0000, "wb_valid after halt");
            compare_value({15'b0, halted}, 16'h0001, "halted after halt");
         end
         if (n_seen == n_writes) begin
            $display("No errors");
            $finish;
         end else begin
            $display("Errors found");
            $fatal(1, "halted rose after only %0d of %0d expected writes", n_seen, n_writes);
         end
      end
   end

endmodule

`default_nettype wire
